/* Makefile */
# Verilator simulation of the convolution core

VERILATOR ?= verilator
TOP       ?= tb_conv_top
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then \
	  echo "simulation reported a failure, see $(LOG)"; exit 1; \
	elif ! grep -q "Simulation passed" $(LOG); then \
	  echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* common/conv_pkg.sv */
// shared widths, depths and beat types for the convolution core
// every stage imports this package to agree on the line layout

package conv_pkg;

  localparam int lanes             = 4;
  localparam int data_w            = 16;
  localparam int addr_w            = 32;
  // up to 16 kernel lines, one per input feature map
  localparam int kernel_depth_bits = 4;
  localparam int fifo_depth_bits   = 4;
  // leaves room for the beats still in flight when almost-full rises
  localparam int fifo_af_level     = 12;

  typedef struct packed {
    logic signed [data_w-1:0] re;
    logic signed [data_w-1:0] im;
  } complex_t;

  // one line of lanes complex values
  typedef complex_t [lanes-1:0] line_t;

  typedef struct packed {
    logic  valid;
    logic  is_kernel;
    line_t data;
  } rsp_beat_t;

  typedef struct packed {
    logic  valid;
    line_t data;
  } prod_beat_t;

  typedef struct packed {
    logic [addr_w-1:0] dest_base;
    logic [7:0]        num_in_maps;
    logic [31:0]       num_out_lines;
  } job_cfg_t;

  typedef struct packed {
    logic              en;
    logic [addr_w-1:0] addr;
    line_t             data;
  } wr_req_t;

endpackage

/* hw/cmul_array.sv */
// lane-parallel complex multiply of an image line with its kernel line
// results wrap to data_w bits and are registered with the valid strobe
`timescale 1ns/1ns

module cmul_array (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 pair_valid,
  input  conv_pkg::line_t      pair_image,
  input  conv_pkg::line_t      pair_kernel,
  output conv_pkg::prod_beat_t prod
);

  import conv_pkg::*;

  line_t prod_line;
  line_t data_q;
  logic  valid_q;

  for (genvar g = 0; g < lanes; g++) begin : g_lane
    logic signed [2*data_w-1:0] rr, ii, ri, ir;
    logic signed [2*data_w-1:0] re_full, im_full;

    assign rr      = pair_image[g].re * pair_kernel[g].re;
    assign ii      = pair_image[g].im * pair_kernel[g].im;
    assign ri      = pair_image[g].re * pair_kernel[g].im;
    assign ir      = pair_image[g].im * pair_kernel[g].re;
    assign re_full = rr - ii;
    assign im_full = ri + ir;
    // keep the low bits only
    assign prod_line[g].re = re_full[data_w-1:0];
    assign prod_line[g].im = im_full[data_w-1:0];
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= pair_valid;
    end
  end

  always_ff @(posedge clk) begin
    data_q <= prod_line;
  end

  assign prod.valid = valid_q;
  assign prod.data  = data_q;

endmodule

/* hw/conv_top.sv */
// top of the frequency-domain convolution core
// router, kernel store, multiplier, accumulator, output FIFO and writer in a chain
`timescale 1ns/1ns

module conv_top (
  input  logic                clk,
  input  logic                reset,
  input  logic                start,
  input  conv_pkg::job_cfg_t  cfg,
  input  conv_pkg::rsp_beat_t rsp,
  output logic                in_almostfull,
  output conv_pkg::wr_req_t   wr,
  input  logic                wr_almostfull,
  output logic                done
);

  import conv_pkg::*;

  logic       busy;
  logic [7:0] num_in_maps;
  logic       kwr_en;
  line_t      kwr_data;
  prod_beat_t img;
  logic       pair_valid;
  line_t      pair_image;
  line_t      pair_kernel;
  prod_beat_t prod;
  logic       push;
  line_t      sum;
  logic       pop;
  line_t      pop_data;
  logic       empty;

  rsp_router i_rsp_router (
    .clk      (clk),
    .reset    (reset),
    .rsp      (rsp),
    .busy     (busy),
    .kwr_en   (kwr_en),
    .kwr_data (kwr_data),
    .img      (img)
  );

  kernel_store i_kernel_store (
    .clk         (clk),
    .reset       (reset),
    .start       (start),
    .num_in_maps (num_in_maps),
    .kwr_en      (kwr_en),
    .kwr_data    (kwr_data),
    .img         (img),
    .pair_valid  (pair_valid),
    .pair_image  (pair_image),
    .pair_kernel (pair_kernel)
  );

  cmul_array i_cmul_array (
    .clk         (clk),
    .reset       (reset),
    .pair_valid  (pair_valid),
    .pair_image  (pair_image),
    .pair_kernel (pair_kernel),
    .prod        (prod)
  );

  map_accumulator i_map_accumulator (
    .clk         (clk),
    .reset       (reset),
    .start       (start),
    .num_in_maps (num_in_maps),
    .prod        (prod),
    .push        (push),
    .sum         (sum)
  );

  out_fifo i_out_fifo (
    .clk        (clk),
    .reset      (reset),
    .push       (push),
    .push_data  (sum),
    .pop        (pop),
    .pop_data   (pop_data),
    .empty      (empty),
    .almostfull (in_almostfull)
  );

  result_writer i_result_writer (
    .clk           (clk),
    .reset         (reset),
    .start         (start),
    .cfg           (cfg),
    .empty         (empty),
    .pop_data      (pop_data),
    .wr_almostfull (wr_almostfull),
    .pop           (pop),
    .wr            (wr),
    .busy          (busy),
    .done          (done),
    .num_in_maps   (num_in_maps)
  );

endmodule

/* hw/kernel_store/kernel_store.sv */
// holds the D1 kernel lines of a job and pairs each image beat with its kernel
// image beat k of a job reads kernel (k mod D1), one cycle of latency
`timescale 1ns/1ns

module kernel_store (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 start,
  input  logic [7:0]           num_in_maps,
  input  logic                 kwr_en,
  input  conv_pkg::line_t      kwr_data,
  input  conv_pkg::prod_beat_t img,
  output logic                 pair_valid,
  output conv_pkg::line_t      pair_image,
  output conv_pkg::line_t      pair_kernel
);

  import conv_pkg::*;

  line_t                       mem [0:(1 << kernel_depth_bits)-1];
  logic [kernel_depth_bits-1:0] wr_ptr;
  logic [kernel_depth_bits-1:0] rd_ptr;
  logic                        rd_last;

  // last map of the group, read pointer goes back to kernel 0
  assign rd_last = (8'(rd_ptr) == num_in_maps - 8'd1);

  always_ff @(posedge clk) begin
    if (reset || start) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (kwr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (img.valid) begin
        rd_ptr <= rd_last ? '0 : rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pair_valid <= 1'b0;
    end else begin
      pair_valid <= img.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (kwr_en) begin
      mem[wr_ptr] <= kwr_data;
    end
    pair_kernel <= mem[rd_ptr];
    pair_image  <= img.data;
  end

endmodule

/* hw/map_accumulator.sv */
// sums D1 consecutive products lane by lane over the input feature maps
// pushes one sum line per group and then starts the next group
`timescale 1ns/1ns

module map_accumulator (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 start,
  input  logic [7:0]           num_in_maps,
  input  conv_pkg::prod_beat_t prod,
  output logic                 push,
  output conv_pkg::line_t      sum
);

  import conv_pkg::*;

  line_t      acc;
  line_t      add_line;
  line_t      next_acc;
  logic [7:0] count;
  logic       last;

  for (genvar g = 0; g < lanes; g++) begin : g_lane
    assign add_line[g].re = acc[g].re + prod.data[g].re;
    assign add_line[g].im = acc[g].im + prod.data[g].im;
  end

  // the first product of a group replaces whatever acc still holds
  assign next_acc = (count == 8'd0) ? prod.data : add_line;
  assign last     = (count == num_in_maps - 8'd1);

  always_ff @(posedge clk) begin
    if (reset || start) begin
      count <= 8'd0;
      push  <= 1'b0;
    end else begin
      push <= prod.valid && last;
      if (prod.valid) begin
        count <= last ? 8'd0 : count + 8'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (prod.valid) begin
      acc <= next_acc;
    end
    if (prod.valid && last) begin
      sum <= next_acc;
    end
  end

endmodule

/* hw/rsp_router.sv */
// first stage of the core: registers the host response and splits it by tag
// kernel beats go to the kernel memory, image beats continue down the pipe
`timescale 1ns/1ns

module rsp_router (
  input  logic                clk,
  input  logic                reset,
  input  conv_pkg::rsp_beat_t rsp,
  input  logic                busy,
  output logic                kwr_en,
  output conv_pkg::line_t     kwr_data,
  output conv_pkg::prod_beat_t img
);

  import conv_pkg::*;

  logic  img_valid_q;
  line_t data_q;

  // responses outside a job are dropped here
  always_ff @(posedge clk) begin
    if (reset) begin
      kwr_en      <= 1'b0;
      img_valid_q <= 1'b0;
    end else begin
      kwr_en      <= rsp.valid && rsp.is_kernel && busy;
      img_valid_q <= rsp.valid && !rsp.is_kernel && busy;
    end
  end

  always_ff @(posedge clk) begin
    data_q <= rsp.data;
  end

  // both destinations see the same registered line
  assign kwr_data  = data_q;
  assign img.valid = img_valid_q;
  assign img.data  = data_q;

endmodule

/* hw/write_path/out_fifo.sv */
// show-ahead output FIFO between the accumulator and the write path
// almostfull is the back-pressure seen by the host as in_almostfull
`timescale 1ns/1ns

module out_fifo (
  input  logic            clk,
  input  logic            reset,
  input  logic            push,
  input  conv_pkg::line_t push_data,
  input  logic            pop,
  output conv_pkg::line_t pop_data,
  output logic            empty,
  output logic            almostfull
);

  import conv_pkg::*;

  line_t                      mem [0:(1 << fifo_depth_bits)-1];
  logic [fifo_depth_bits-1:0] wr_ptr;
  logic [fifo_depth_bits-1:0] rd_ptr;
  logic [fifo_depth_bits:0]   count;
  logic                       do_push;
  logic                       do_pop;

  assign do_push = push && (count != (fifo_depth_bits+1)'(1 << fifo_depth_bits));
  assign do_pop  = pop && !empty;

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // head entry is visible without a read cycle
  assign pop_data   = mem[rd_ptr];
  assign empty      = (count == '0);
  assign almostfull = (count >= (fifo_depth_bits+1)'(fifo_af_level));

endmodule

/* hw/write_path/result_writer.sv */
// job control and write side: latches the job on start, drains the FIFO
// into consecutive write requests and flags done after the last write
`timescale 1ns/1ns

module result_writer (
  input  logic               clk,
  input  logic               reset,
  input  logic               start,
  input  conv_pkg::job_cfg_t cfg,
  input  logic               empty,
  input  conv_pkg::line_t    pop_data,
  input  logic               wr_almostfull,
  output logic               pop,
  output conv_pkg::wr_req_t  wr,
  output logic               busy,
  output logic               done,
  output logic [7:0]         num_in_maps
);

  import conv_pkg::*;

  job_cfg_t          cfg_q;
  logic [addr_w-1:0] next_addr;
  logic [31:0]       wr_cnt;
  logic              wr_en_q;
  logic [addr_w-1:0] wr_addr_q;
  line_t             wr_data_q;

  assign pop = !empty && !wr_almostfull;

  always_ff @(posedge clk) begin
    if (reset) begin
      busy    <= 1'b0;
      done    <= 1'b0;
      wr_en_q <= 1'b0;
      wr_cnt  <= '0;
    end else begin
      wr_en_q <= pop;
      if (start) begin
        busy   <= 1'b1;
        done   <= 1'b0;
        wr_cnt <= '0;
      end else if (wr_en_q) begin
        wr_cnt <= wr_cnt + 1'b1;
        if (wr_cnt == cfg_q.num_out_lines - 32'd1) begin
          busy <= 1'b0;
          done <= 1'b1;
        end
      end else if (!busy && !done) begin
        // idle out of reset, ready for the first start
        done <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      cfg_q     <= cfg;
      next_addr <= cfg.dest_base;
    end else if (pop) begin
      next_addr <= next_addr + 1'b1;
    end
    if (pop) begin
      wr_addr_q <= next_addr;
      wr_data_q <= pop_data;
    end
  end

  assign wr.en       = wr_en_q;
  assign wr.addr     = wr_addr_q;
  assign wr.data     = wr_data_q;
  assign num_in_maps = cfg_q.num_in_maps;

endmodule

/* testbench/conv_top_assert.sv */
// protocol checks on the write side of the convolution core
// bound into conv_top next to the testbench
`timescale 1ns/1ns

module conv_top_assert (
  input logic              clk,
  input logic              reset,
  input logic              start,
  input logic              wr_almostfull,
  input logic              done,
  input conv_pkg::wr_req_t wr
);

  import conv_pkg::*;

  logic [addr_w-1:0] last_addr;
  logic              seen_wr;

  // previous write address of the running job
  always_ff @(posedge clk) begin
    if (reset || start) begin
      seen_wr <= 1'b0;
    end else if (wr.en) begin
      seen_wr <= 1'b1;
    end
    if (wr.en) begin
      last_addr <= wr.addr;
    end
  end

  a_no_write_on_full: assert property (@(posedge clk) disable iff (reset)
    wr.en |-> $past(!wr_almostfull))
    else $error("write issued while wr_almostfull was high");

  a_quiet_after_reset: assert property (@(posedge clk)
    $past(reset) |-> (!wr.en && !done))
    else $error("wr.en or done high right after reset");

  a_addr_step: assert property (@(posedge clk) disable iff (reset)
    (wr.en && seen_wr) |-> (wr.addr == last_addr + addr_w'(1)))
    else $error("write address did not advance by one");

endmodule

bind conv_top conv_top_assert i_conv_top_assert (
  .clk           (clk),
  .reset         (reset),
  .start         (start),
  .wr_almostfull (wr_almostfull),
  .done          (done),
  .wr            (wr)
);

/* testbench/tb_conv_top.sv */
// testbench for the convolution core
// streams kernels and images into conv_top and checks every write request
// and the input almost-full flag against a reference model of the core
`timescale 1ns/1ns

module tb_conv_top;

  import conv_pkg::*;

  localparam int max_wait = 2000;

  logic      clk;
  logic      reset;
  logic      start;
  job_cfg_t  cfg;
  rsp_beat_t rsp;
  logic      in_almostfull;
  wr_req_t   wr;
  logic      wr_almostfull;
  logic      done;

  // job data kept for the reference model
  line_t             kern [0:(1 << kernel_depth_bits)-1];
  line_t             imgs [$];
  line_t             exp_q [$];
  logic [addr_w-1:0] exp_addr;
  int                wr_count;
  logic              prev_waf;
  logic              stall_en;
  int                stall_left;
  // set with the image beat that closes a group of D1 beats
  logic              beat_ends_group;
  logic [4:0]        push_pipe;
  int                fifo_model;
  int                errors;
  int                tests_run;
  int                tests_failed;

  conv_top i_dut (
    .clk           (clk),
    .reset         (reset),
    .start         (start),
    .cfg           (cfg),
    .rsp           (rsp),
    .in_almostfull (in_almostfull),
    .wr            (wr),
    .wr_almostfull (wr_almostfull),
    .done          (done)
  );

  always #10 clk = ~clk;

  // complex product of one lane wrapped to data_w bits
  function automatic complex_t cmul_ref(complex_t a, complex_t b);
    complex_t r;
    longint   re_full;
    longint   im_full;
    re_full = longint'(a.re) * longint'(b.re) - longint'(a.im) * longint'(b.im);
    im_full = longint'(a.re) * longint'(b.im) + longint'(a.im) * longint'(b.re);
    r.re = re_full[data_w-1:0];
    r.im = im_full[data_w-1:0];
    return r;
  endfunction

  // expected output line g as the sum over the D1 maps of image times kernel (k mod D1)
  function automatic line_t ref_line(int d1, int g);
    line_t    acc;
    complex_t p;
    acc = '0;
    for (int m = 0; m < d1; m++) begin
      for (int l = 0; l < lanes; l++) begin
        p = cmul_ref(imgs[g*d1+m][l], kern[m][l]);
        acc[l].re = acc[l].re + p.re;
        acc[l].im = acc[l].im + p.im;
      end
    end
    return acc;
  endfunction

  function automatic line_t rand_line();
    line_t v;
    for (int l = 0; l < lanes; l++) begin
      v[l] = $urandom;
    end
    return v;
  endfunction

  // host side write back-pressure in random stretches
  always @(posedge clk) begin
    #1;
    if (!stall_en) begin
      wr_almostfull = 1'b0;
    end else if (stall_left > 0) begin
      wr_almostfull = 1'b1;
      stall_left--;
    end else if ($urandom_range(3, 0) == 0) begin
      wr_almostfull = 1'b1;
      stall_left = $urandom_range(8, 1);
    end else begin
      wr_almostfull = 1'b0;
    end
  end

  // compares each write with the next expected line and address
  always @(negedge clk) begin
    line_t exp_line;
    if (!reset) begin
      // a group sum lands in the FIFO four cycles after the router takes its last beat
      if (push_pipe[4]) begin
        fifo_model++;
      end
      push_pipe = {push_pipe[3:0], rsp.valid && beat_ends_group};
      if (wr.en) begin
        fifo_model--;
        assert (!prev_waf) else begin
          $display("write at %0t issued while wr_almostfull was high the cycle before", $time);
          errors++;
        end
        assert (exp_q.size() > 0) else begin
          $display("unexpected write at %0t to address %h with no line left to compare",
                   $time, wr.addr);
          errors++;
        end
        if (exp_q.size() > 0) begin
          exp_line = exp_q.pop_front();
          assert (wr.data == exp_line) else begin
            $display("FAILED at %0t: wr.data got %h expected %h", $time, wr.data, exp_line);
            errors++;
          end
          assert (wr.addr == exp_addr) else begin
            $display("FAILED at %0t: wr.addr got %h expected %h", $time, wr.addr, exp_addr);
            errors++;
          end
          exp_addr = exp_addr + 1;
        end
        wr_count++;
      end
      assert (in_almostfull == (fifo_model >= fifo_af_level)) else begin
        $display("FAILED at %0t: in_almostfull got %b expected %b", $time, in_almostfull,
                 fifo_model >= fifo_af_level);
        errors++;
      end
      prev_waf = wr_almostfull;
    end
  end

  task automatic wait_for_done();
    int waited;
    waited = 0;
    while (!done && waited < max_wait) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (!done) begin
      $display("timeout at %0t: done did not rise within %0d cycles", $time, max_wait);
      errors++;
    end
  endtask

  // sends one beat and holds it back while the core signals almost-full
  task automatic send_beat(input logic is_kernel, input logic ends_group,
                           input line_t data);
    int waited;
    waited = 0;
    while (in_almostfull && waited < max_wait) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (in_almostfull) begin
      $display("timeout at %0t: in_almostfull stayed high, beat dropped", $time);
      errors++;
    end else begin
      rsp.valid       = 1'b1;
      rsp.is_kernel   = is_kernel;
      rsp.data        = data;
      beat_ends_group = ends_group;
      @(posedge clk);
      #1;
      rsp.valid       = 1'b0;
      beat_ends_group = 1'b0;
    end
  endtask

  task automatic run_job(input int d1, input int n, input logic [addr_w-1:0] base,
                         input logic stall);
    imgs.delete();
    exp_q.delete();
    for (int i = 0; i < d1; i++) begin
      kern[i] = rand_line();
    end
    for (int j = 0; j < d1 * n; j++) begin
      imgs.push_back(rand_line());
    end
    for (int g = 0; g < n; g++) begin
      exp_q.push_back(ref_line(d1, g));
    end
    exp_addr = base;
    wr_count = 0;
    wait_for_done();
    cfg.dest_base     = base;
    cfg.num_in_maps   = 8'(d1);
    cfg.num_out_lines = 32'(n);
    start    = 1'b1;
    stall_en = stall;
    @(posedge clk);
    #1;
    start = 1'b0;
    assert (!done) else begin
      $display("FAILED at %0t: done got %b expected %b", $time, done, 1'b0);
      errors++;
    end
    for (int i = 0; i < d1; i++) begin
      send_beat(1'b1, 1'b0, kern[i]);
    end
    for (int j = 0; j < d1 * n; j++) begin
      send_beat(1'b0, (j % d1) == d1 - 1, imgs[j]);
    end
    wait_for_done();
    stall_en = 1'b0;
    assert (wr_count == n) else begin
      $display("FAILED at %0t: write count got %0d expected %0d", $time, wr_count, n);
      errors++;
    end
    // no write may follow done
    repeat (6) @(posedge clk);
    #1;
    assert (wr_count == n) else begin
      $display("FAILED at %0t: write count after done got %0d expected %0d", $time,
               wr_count, n);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    tests_run++;
    if (errors == errors_before) begin
      $display("result: test %0d (%s) ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("result: test %0d (%s) has %0d errors", tests_run, name,
               errors - errors_before);
    end
  endtask

  initial begin
    int err0;
    clk             = 1'b0;
    reset           = 1'b1;
    start           = 1'b0;
    cfg             = '0;
    rsp             = '0;
    wr_almostfull   = 1'b0;
    prev_waf        = 1'b0;
    stall_en        = 1'b0;
    stall_left      = 0;
    beat_ends_group = 1'b0;
    push_pipe       = '0;
    fifo_model      = 0;
    errors          = 0;
    tests_run       = 0;
    tests_failed    = 0;
    wr_count        = 0;
    exp_addr        = '0;
    void'($urandom(32'hef8ca9e4));
    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;

    err0 = errors;
    run_job(1, 4, 32'h0000_1000, 1'b0);
    report_test("single group", err0);

    err0 = errors;
    run_job(5, 6, 32'h0000_2000, 1'b0);
    report_test("summation over maps", err0);

    err0 = errors;
    run_job(2, 9, 32'h0000_3000, 1'b0);
    report_test("addresses and done", err0);

    err0 = errors;
    run_job(1, 24, 32'h0000_4000, 1'b1);
    report_test("write back-pressure", err0);

    // beats outside a job must be dropped by the router
    err0 = errors;
    wait_for_done();
    send_beat(1'b0, 1'b0, rand_line());
    send_beat(1'b1, 1'b0, rand_line());
    send_beat(1'b0, 1'b0, rand_line());
    run_job(4, 5, 32'h0000_8000, 1'b0);
    report_test("second job", err0);

    $display("tests: %0d run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* verilog.f */
common/conv_pkg.sv
hw/rsp_router.sv
hw/kernel_store/kernel_store.sv
hw/cmul_array.sv
hw/map_accumulator.sv
hw/write_path/out_fifo.sv
hw/write_path/result_writer.sv
hw/conv_top.sv
testbench/conv_top_assert.sv
testbench/tb_conv_top.sv
